/* logic/mcore_defs.svh */
// sizes and the partition boundary of the shared data memory
// addresses are byte addresses; memory words are MCORE_DATA_NBITS wide
`ifndef MCORE_DEFS_SVH
`define MCORE_DEFS_SVH

// requester ports on the memory side
`define MCORE_NUM_PORTS 2

// message field widths
`define MCORE_ADDR_NBITS 16
`define MCORE_DATA_NBITS 32
`define MCORE_OPAQUE_NBITS 8

// main memory depth in words
`define MCORE_MEM_NWORDS 256

// insecure requests at or above this byte address are denied
`define MCORE_PAR_ADDR 16'h0200

`endif

/* logic/mcore_ctrl_pkg.sv */
// security domain and control FSM encodings
`default_nettype none

package mcore_ctrl_pkg;

	// domain tag carried on every request
	typedef enum logic {
		DOM_INSECURE = 1'b0,
		DOM_SECURE   = 1'b1
	} sec_domain_e;

	// per-port guard FSM
	typedef enum logic [1:0] {
		GUARD_IDLE,
		GUARD_FWD,
		GUARD_WAIT,
		GUARD_DENY
	} guard_state_e;

	// blocking arbiter, one memory access in flight
	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

endpackage

`default_nettype wire

/* logic/mem_msg_pkg.sv */
// memory request and response messages, kept whole on every link
// requires mcore_ctrl_pkg to be compiled first
`default_nettype none

`include "mcore_defs.svh"

package mem_msg_pkg;

	import mcore_ctrl_pkg::*;

	typedef enum logic {
		MEM_READ  = 1'b0,
		MEM_WRITE = 1'b1
	} mem_opcode_e;

	// 58 bits
	typedef struct packed {
		mem_opcode_e                    opcode;
		logic [`MCORE_OPAQUE_NBITS-1:0] opaque;
		logic [`MCORE_ADDR_NBITS-1:0]   addr;
		logic [`MCORE_DATA_NBITS-1:0]   data;
		sec_domain_e                    domain;
	} mem_req_t;

	// 42 bits, fail set only by a guard
	typedef struct packed {
		mem_opcode_e                    opcode;
		logic [`MCORE_OPAQUE_NBITS-1:0] opaque;
		logic [`MCORE_DATA_NBITS-1:0]   data;
		logic                           fail;
	} mem_resp_t;

endpackage

`default_nettype wire

/* logic/port_domain_guard.sv */
// one request at a time per port; req_rdy stays low until its response transfers
// denied requests never reach memory and answer after one cycle
`default_nettype none

`include "mcore_defs.svh"

module port_domain_guard
	import mem_msg_pkg::*, mcore_ctrl_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst_n,

	input  wire mem_req_t  req,
	input  wire logic      req_val,
	output logic           req_rdy,

	output mem_resp_t      resp,
	output logic           resp_val,
	input  wire logic      resp_rdy,

	output mem_req_t       fwd_req,
	output logic           fwd_val,
	input  wire logic      fwd_rdy,

	input  wire mem_resp_t fwd_resp,
	input  wire logic      fwd_resp_val,
	output logic           fwd_resp_rdy
);

	guard_state_e state_q;
	guard_state_e state_d;
	mem_req_t     req_q;
	logic         deny;

	// insecure domain may not touch the upper partition
	assign deny = (req.domain == DOM_INSECURE) && (req.addr >= `MCORE_PAR_ADDR);

	always_ff @(posedge clk) begin
		if (req_val && req_rdy) begin
			req_q <= req;
		end
	end

	//============================================================
	// control FSM
	//============================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= GUARD_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			GUARD_IDLE: begin
				if (req_val) begin
					state_d = deny ? GUARD_DENY : GUARD_FWD;
				end
			end
			GUARD_FWD: begin
				if (fwd_rdy) begin
					state_d = GUARD_WAIT;
				end
			end
			GUARD_WAIT: begin
				if (fwd_resp_val && resp_rdy) begin
					state_d = GUARD_IDLE;
				end
			end
			GUARD_DENY: begin
				if (resp_rdy) begin
					state_d = GUARD_IDLE;
				end
			end
		endcase
	end

	//============================================================
	// handshake outputs
	//============================================================

	assign req_rdy      = (state_q == GUARD_IDLE);
	assign fwd_req      = req_q;
	assign fwd_val      = (state_q == GUARD_FWD);
	assign fwd_resp_rdy = (state_q == GUARD_WAIT) && resp_rdy;

	always_comb begin
		resp     = fwd_resp;
		resp_val = 1'b0;
		if (state_q == GUARD_DENY) begin
			// local fail answer, tag and opcode echoed
			resp.opcode = req_q.opcode;
			resp.opaque = req_q.opaque;
			resp.data   = '0;
			resp.fail   = 1'b1;
			resp_val    = 1'b1;
		end else if (state_q == GUARD_WAIT) begin
			resp_val = fwd_resp_val;
		end
	end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// round-robin and blocking: a new grant waits until the previous response transfers
// a stalled response on the granted port stalls every other port
`default_nettype none

`include "mcore_defs.svh"

module mem_arbiter
	import mem_msg_pkg::*, mcore_ctrl_pkg::*;
(
	input  wire logic                         clk,
	input  wire logic                         rst_n,

	input  wire mem_req_t                     fwd_req [`MCORE_NUM_PORTS],
	input  wire logic [`MCORE_NUM_PORTS-1:0]  fwd_val,
	output logic [`MCORE_NUM_PORTS-1:0]       fwd_rdy,

	output mem_resp_t                         fwd_resp [`MCORE_NUM_PORTS],
	output logic [`MCORE_NUM_PORTS-1:0]       fwd_resp_val,
	input  wire logic [`MCORE_NUM_PORTS-1:0]  fwd_resp_rdy,

	output mem_req_t                          mem_req,
	output logic                              mem_req_val,
	input  wire logic                         mem_req_rdy,

	input  wire mem_resp_t                    mem_resp,
	input  wire logic                         mem_resp_val,
	output logic                              mem_resp_rdy
);

	localparam int n_ports   = `MCORE_NUM_PORTS;
	localparam int ptr_nbits = (n_ports > 1) ? $clog2(n_ports) : 1;

	arb_state_e           state_q;
	logic [ptr_nbits-1:0] ptr_q;
	logic [ptr_nbits-1:0] grant_q;
	logic [ptr_nbits-1:0] pick;
	logic                 any_val;

	// first valid port at or after the priority pointer
	always_comb begin
		int idx;
		pick    = ptr_q;
		any_val = 1'b0;
		for (int i = 0; i < n_ports; i++) begin
			idx = (int'(ptr_q) + i) % n_ports;
			if (!any_val && fwd_val[idx]) begin
				any_val = 1'b1;
				pick    = idx[ptr_nbits-1:0];
			end
		end
	end

	assign mem_req      = fwd_req[pick];
	assign mem_req_val  = (state_q == ARB_IDLE) && any_val;
	assign mem_resp_rdy = (state_q == ARB_BUSY) && fwd_resp_rdy[grant_q];

	// response payload goes everywhere, val only to the granted port
	always_comb begin
		for (int i = 0; i < n_ports; i++) begin
			fwd_rdy[i]      = mem_req_val && (pick == i) && mem_req_rdy;
			fwd_resp[i]     = mem_resp;
			fwd_resp_val[i] = (state_q == ARB_BUSY) && (grant_q == i) && mem_resp_val;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ARB_IDLE;
			ptr_q   <= '0;
			grant_q <= '0;
		end else begin
			case (state_q)
				ARB_IDLE: begin
					if (mem_req_val && mem_req_rdy) begin
						grant_q <= pick;
						state_q <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (mem_resp_val && mem_resp_rdy) begin
						state_q <= ARB_IDLE;
						// served port drops to lowest priority
						ptr_q   <= (grant_q == n_ports - 1) ? '0 : grant_q + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/main_mem.sv */
// word array, addresses wrap modulo nwords; response registered and held until taken
// contents have no reset, mem_clear zeros every word and blocks requests
`default_nettype none

`include "mcore_defs.svh"

module main_mem
	import mem_msg_pkg::*;
#(
	parameter int nwords = `MCORE_MEM_NWORDS
)
(
	input  wire logic      clk,
	input  wire logic      rst_n,
	input  wire logic      mem_clear,

	input  wire mem_req_t  mem_req,
	input  wire logic      mem_req_val,
	output logic           mem_req_rdy,

	output mem_resp_t      mem_resp,
	output logic           mem_resp_val,
	input  wire logic      mem_resp_rdy
);

	localparam int off_nbits = $clog2(`MCORE_DATA_NBITS / 8);
	localparam int idx_nbits = (nwords > 1) ? $clog2(nwords) : 1;

	logic [`MCORE_DATA_NBITS-1:0] mem [nwords];
	logic [idx_nbits-1:0]         idx;
	logic                         req_go;

	// word index from the bits above the byte offset
	assign idx         = mem_req.addr[off_nbits +: idx_nbits];
	assign mem_req_rdy = !mem_resp_val && !mem_clear;
	assign req_go      = mem_req_val && mem_req_rdy;

	always_ff @(posedge clk) begin
		if (mem_clear) begin
			for (int i = 0; i < nwords; i++) begin
				mem[i] <= '0;
			end
		end else if (req_go && (mem_req.opcode == MEM_WRITE)) begin
			mem[idx] <= mem_req.data;
		end
	end

	// writes answer with zero data
	always_ff @(posedge clk) begin
		if (req_go) begin
			mem_resp.opcode <= mem_req.opcode;
			mem_resp.opaque <= mem_req.opaque;
			mem_resp.data   <= (mem_req.opcode == MEM_WRITE) ? '0 : mem[idx];
			mem_resp.fail   <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_resp_val <= 1'b0;
		end else if (req_go) begin
			mem_resp_val <= 1'b1;
		end else if (mem_resp_rdy) begin
			mem_resp_val <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/mcore_mem_sys.sv */
// shared data memory with one domain guard per requester port
// each port has at most one request outstanding
`default_nettype none

`include "mcore_defs.svh"

module mcore_mem_sys
	import mem_msg_pkg::*;
(
	input  wire logic                         clk,
	input  wire logic                         rst_n,
	input  wire logic                         mem_clear,

	input  wire mem_req_t                     req [`MCORE_NUM_PORTS],
	input  wire logic [`MCORE_NUM_PORTS-1:0]  req_val,
	output logic [`MCORE_NUM_PORTS-1:0]       req_rdy,

	output mem_resp_t                         resp [`MCORE_NUM_PORTS],
	output logic [`MCORE_NUM_PORTS-1:0]       resp_val,
	input  wire logic [`MCORE_NUM_PORTS-1:0]  resp_rdy
);

	mem_req_t                      fwd_req [`MCORE_NUM_PORTS];
	logic [`MCORE_NUM_PORTS-1:0]   fwd_val;
	logic [`MCORE_NUM_PORTS-1:0]   fwd_rdy;
	mem_resp_t                     fwd_resp [`MCORE_NUM_PORTS];
	logic [`MCORE_NUM_PORTS-1:0]   fwd_resp_val;
	logic [`MCORE_NUM_PORTS-1:0]   fwd_resp_rdy;

	mem_req_t                      mem_req;
	logic                          mem_req_val;
	logic                          mem_req_rdy;
	mem_resp_t                     mem_resp;
	logic                          mem_resp_val;
	logic                          mem_resp_rdy;

	//============================================================
	// per-port guards
	//============================================================

	for (genvar i = 0; i < `MCORE_NUM_PORTS; i++) begin : g_guard
		port_domain_guard u_guard (
			.clk          (clk),
			.rst_n        (rst_n),
			.req          (req[i]),
			.req_val      (req_val[i]),
			.req_rdy      (req_rdy[i]),
			.resp         (resp[i]),
			.resp_val     (resp_val[i]),
			.resp_rdy     (resp_rdy[i]),
			.fwd_req      (fwd_req[i]),
			.fwd_val      (fwd_val[i]),
			.fwd_rdy      (fwd_rdy[i]),
			.fwd_resp     (fwd_resp[i]),
			.fwd_resp_val (fwd_resp_val[i]),
			.fwd_resp_rdy (fwd_resp_rdy[i])
		);
	end

	//============================================================
	// arbiter and memory
	//============================================================

	mem_arbiter u_arbiter (
		.clk          (clk),
		.rst_n        (rst_n),
		.fwd_req      (fwd_req),
		.fwd_val      (fwd_val),
		.fwd_rdy      (fwd_rdy),
		.fwd_resp     (fwd_resp),
		.fwd_resp_val (fwd_resp_val),
		.fwd_resp_rdy (fwd_resp_rdy),
		.mem_req      (mem_req),
		.mem_req_val  (mem_req_val),
		.mem_req_rdy  (mem_req_rdy),
		.mem_resp     (mem_resp),
		.mem_resp_val (mem_resp_val),
		.mem_resp_rdy (mem_resp_rdy)
	);

	main_mem #(
		.nwords (`MCORE_MEM_NWORDS)
	) u_mem (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_clear    (mem_clear),
		.mem_req      (mem_req),
		.mem_req_val  (mem_req_val),
		.mem_req_rdy  (mem_req_rdy),
		.mem_resp     (mem_resp),
		.mem_resp_val (mem_resp_val),
		.mem_resp_rdy (mem_resp_rdy)
	);

endmodule

`default_nettype wire

/* dv/tb_mcore_mem_sys.sv */
// self-checking testbench, one request outstanding per port
// concurrent traffic splits words by parity so the model can update per port at acceptance
`default_nettype none

`include "mcore_defs.svh"

module tb_mcore_mem_sys
	import mem_msg_pkg::*, mcore_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_ports    = `MCORE_NUM_PORTS;
	localparam int n_words    = `MCORE_MEM_NWORDS;
	localparam int wait_limit = 400;

	logic                clk;
	logic                rst_n;
	logic                mem_clear;
	mem_req_t            req [n_ports];
	logic [n_ports-1:0]  req_val;
	logic [n_ports-1:0]  req_rdy;
	mem_resp_t           resp [n_ports];
	logic [n_ports-1:0]  resp_val;
	logic [n_ports-1:0]  resp_rdy;

	logic [31:0]                  lfsr_q;
	logic [`MCORE_DATA_NBITS-1:0] model_mem [n_words];
	mem_resp_t                    exp_q [n_ports][$];
	mem_req_t                     traffic_q [n_ports][$];
	logic [7:0]                   tag_q [n_ports];
	logic [n_ports-1:0]           held_val_q;
	mem_resp_t                    held_resp_q [n_ports];

	mcore_mem_sys u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_clear (mem_clear),
		.req       (req),
		.req_val   (req_val),
		.req_rdy   (req_rdy),
		.resp      (resp),
		.resp_val  (resp_val),
		.resp_rdy  (resp_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//============================================================
	// helpers
	//============================================================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		abort_run($sformatf("Fail at %0t ns: %s expected %h actual %h",
			$time, name, exp_v, act_v));
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	function automatic int outstanding();
		int sum;
		sum = 0;
		for (int p = 0; p < n_ports; p++) begin
			sum += exp_q[p].size();
		end
		return sum;
	endfunction

	// drive one request, then predict its response at acceptance
	task automatic send_req(input int p, input mem_opcode_e op, input logic [15:0] addr,
			input logic [31:0] data, input sec_domain_e dom);
		mem_req_t  r;
		mem_resp_t e;
		int        n;
		int        widx;
		r.opcode = op;
		r.opaque = tag_q[p];
		r.addr   = addr;
		r.data   = data;
		r.domain = dom;
		tag_q[p] = tag_q[p] + 8'd1;
		@(posedge clk);
		req[p]     <= r;
		req_val[p] <= 1'b1;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!req_rdy[p] && n < wait_limit);
		if (!req_rdy[p]) begin
			abort_run($sformatf("port %0d hung waiting for its request to be accepted", p));
		end else begin
			req_val[p] <= 1'b0;
			widx     = (addr >> 2) % n_words;
			e.opcode = op;
			e.opaque = r.opaque;
			e.data   = '0;
			e.fail   = 1'b0;
			if (dom == DOM_INSECURE && addr >= `MCORE_PAR_ADDR) begin
				e.fail = 1'b1;
			end else if (op == MEM_WRITE) begin
				model_mem[widx] = data;
			end else begin
				e.data = model_mem[widx];
			end
			exp_q[p].push_back(e);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (outstanding() != 0 && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		for (int p = 0; p < n_ports; p++) begin
			if (exp_q[p].size() != 0) begin
				abort_run($sformatf("port %0d hung with %0d responses missing",
					p, exp_q[p].size()));
			end
		end
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		mem_clear <= 1'b1;
		@(posedge clk);
		mem_clear <= 1'b0;
		for (int w = 0; w < n_words; w++) begin
			model_mem[w] = '0;
		end
	endtask

	// requests for all ports drawn in one fixed order
	// port p only touches words whose index parity equals p
	task automatic draw_traffic(input int count);
		logic [31:0] v;
		mem_req_t    r;
		for (int k = 0; k < count; k++) begin
			for (int p = 0; p < n_ports; p++) begin
				v         = take_bits(1);
				r.opcode  = v[0] ? MEM_WRITE : MEM_READ;
				v         = take_bits(1);
				r.domain  = v[0] ? DOM_SECURE : DOM_INSECURE;
				v         = take_bits(11);
				r.addr    = {5'b0, v[10:0]};
				r.addr[2] = p[0];
				r.data    = take_bits(32);
				r.opaque  = '0;
				traffic_q[p].push_back(r);
			end
		end
	endtask

	task automatic replay_traffic(input int p);
		mem_req_t r;
		while (traffic_q[p].size() != 0) begin
			r = traffic_q[p].pop_front();
			send_req(p, r.opcode, r.addr, r.data, r.domain);
		end
	endtask

	//============================================================
	// response checks
	//============================================================

	always @(posedge clk) begin
		mem_resp_t e;
		if (!rst_n) begin
			held_val_q <= '0;
		end else begin
			for (int i = 0; i < n_ports; i++) begin
				// a stalled response must stay put
				if (held_val_q[i]) begin
					assert (resp_val[i])
					else report_mismatch($sformatf("resp_val[%0d]", i), 1'b1, resp_val[i]);
					assert (resp[i] === held_resp_q[i])
					else report_mismatch($sformatf("resp[%0d]", i), held_resp_q[i], resp[i]);
				end
				if (resp_val[i] && resp_rdy[i]) begin
					if (exp_q[i].size() == 0) begin
						abort_run($sformatf("port %0d gave a response with no request", i));
					end else begin
						e = exp_q[i].pop_front();
						assert (resp[i] === e)
						else report_mismatch($sformatf("resp[%0d]", i), e, resp[i]);
					end
				end
				held_resp_q[i] <= resp[i];
			end
			held_val_q <= resp_val & ~resp_rdy;
		end
	end

	//============================================================
	// stimulus
	//============================================================

	initial begin
		rst_n     = 1'b0;
		mem_clear = 1'b0;
		req_val   = '0;
		resp_rdy  = '1;
		lfsr_q    = 32'h163d;
		for (int p = 0; p < n_ports; p++) begin
			req[p]   = '0;
			tag_q[p] = 8'(p * 16);
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		assert (req_rdy == {n_ports{1'b1}})
		else report_mismatch("req_rdy", {n_ports{1'b1}}, req_rdy);
		assert (resp_val == '0)
		else report_mismatch("resp_val", '0, resp_val);

		// memory contents start unknown
		pulse_clear();

		// secure accesses on both sides of the boundary
		send_req(0, MEM_WRITE, 16'h0040, 32'ha5a5_0001, DOM_SECURE);
		send_req(0, MEM_READ, 16'h0040, 32'h0, DOM_SECURE);
		send_req(1, MEM_WRITE, 16'h0310, 32'h1234_5678, DOM_SECURE);
		send_req(1, MEM_READ, 16'h0310, 32'h0, DOM_SECURE);
		wait_drain();

		// insecure above the boundary, word must survive
		send_req(0, MEM_WRITE, 16'h0310, 32'hdead_beef, DOM_INSECURE);
		send_req(0, MEM_READ, 16'h0310, 32'h0, DOM_INSECURE);
		send_req(1, MEM_WRITE, `MCORE_PAR_ADDR, 32'h0bad_0bad, DOM_INSECURE);
		send_req(1, MEM_READ, 16'h0310, 32'h0, DOM_SECURE);
		wait_drain();

		// insecure below the boundary
		send_req(1, MEM_WRITE, 16'h01fc, 32'h0f0f_3c3c, DOM_INSECURE);
		wait_drain();
		send_req(0, MEM_READ, 16'h01fc, 32'h0, DOM_INSECURE);
		wait_drain();

		draw_traffic(80);
		fork
			replay_traffic(0);
			replay_traffic(1);
		join
		wait_drain();

		// stall port 0 while port 1 competes
		@(posedge clk);
		resp_rdy[0] <= 1'b0;
		fork
			send_req(0, MEM_READ, 16'h0040, 32'h0, DOM_SECURE);
			send_req(1, MEM_READ, 16'h0310, 32'h0, DOM_SECURE);
		join
		repeat (12) @(posedge clk);
		resp_rdy[0] <= 1'b1;
		wait_drain();

		// earlier words read back as zero
		pulse_clear();
		send_req(0, MEM_READ, 16'h0040, 32'h0, DOM_SECURE);
		send_req(1, MEM_READ, 16'h0310, 32'h0, DOM_SECURE);
		send_req(0, MEM_READ, 16'h01fc, 32'h0, DOM_INSECURE);
		wait_drain();

		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+logic
logic/mcore_ctrl_pkg.sv
logic/mem_msg_pkg.sv
logic/port_domain_guard.sv
logic/mem_arbiter.sv
logic/main_mem.sv
logic/mcore_mem_sys.sv
dv/tb_mcore_mem_sys.sv
